// ==== Bender.yml ====
package:
  name: pixel_blend_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/BlendPkg.sv
      - source/ColorMixer.sv
      - source/ColorBlender.sv
      - source/BlendControl.sv
      - source/PixelBlendUnit.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/PixelBlendTb.sv

// ==== all.f ====
+incdir+source
source/BlendPkg.sv
source/ColorMixer.sv
source/ColorBlender.sv
source/BlendControl.sv
source/PixelBlendUnit.sv
verif/PixelBlendTb.sv

// ==== source/BlendControl.sv ====
// BlendControl, Wishbone classic slave with blend CONFIG and pixel COUNT registers
`timescale 1ns/10ps
`include "blend_params.svh"

module BlendControl
    import BlendPkg::*;
(
    input  logic                                    aclk,
    input  logic                                    arstN,

    input  logic                                    wbCyc,
    input  logic                                    wbStb,
    input  logic                                    wbWe,
    input  logic [`BLEND_WB_ADDR_WIDTH - 1 : 0]     wbAdr,
    input  logic [`BLEND_WB_DATA_WIDTH - 1 : 0]     wbDatW,
    input  logic [`BLEND_WB_DATA_WIDTH / 8 - 1 : 0] wbSel,
    output logic [`BLEND_WB_DATA_WIDTH - 1 : 0]     wbDatR,
    output logic                                    wbAck,

    input  logic                                    resultValid,
    output blendConfig_t                            blendConfig
);

    localparam logic [`BLEND_WB_ADDR_WIDTH - 1 : 0] CONFIG_ADDR = `BLEND_REG_CONFIG;
    localparam logic [`BLEND_WB_ADDR_WIDTH - 1 : 0] COUNT_ADDR = `BLEND_REG_COUNT;

    busState_e                              state;
    logic                                   busWrite;
    blendFactor_e                           srcFactor;
    blendFactor_e                           dstFactor;
    logic                                   enable;
    logic [`BLEND_WB_DATA_WIDTH - 1 : 0]    pixelCount;

    // One ack per strobe, then back to idle
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (wbCyc && wbStb)
                        state <= ACK;
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign wbAck = (state == ACK);

    // Writes land on the acknowledge edge
    assign busWrite = (state == ACK) && wbCyc && wbStb && wbWe;

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            srcFactor <= ONE;
            dstFactor <= ZERO;
            enable <= 1'b0;
        end
        else if (busWrite && (wbAdr == CONFIG_ADDR))
        begin
            if (wbSel[0])
            begin
                srcFactor <= blendFactor_e'(wbDatW[3 : 0]);
                dstFactor <= blendFactor_e'(wbDatW[7 : 4]);
            end
            if (wbSel[1])
                enable <= wbDatW[8];
        end
    end

    // Clear wins over a same-cycle increment
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            pixelCount <= '0;
        else if (busWrite && (wbAdr == COUNT_ADDR))
            pixelCount <= '0;
        else if (resultValid)
            pixelCount <= pixelCount + 1'b1;
    end

    always_comb
    begin
        wbDatR = '0;
        if (wbAdr == CONFIG_ADDR)
            wbDatR[8 : 0] = {enable, dstFactor, srcFactor};
        else if (wbAdr == COUNT_ADDR)
            wbDatR = pixelCount;
    end

    // Disabled means plain source pass-through
    always_comb
    begin
        if (enable)
        begin
            blendConfig.srcFactor = srcFactor;
            blendConfig.dstFactor = dstFactor;
        end
        else
        begin
            blendConfig.srcFactor = ONE;
            blendConfig.dstFactor = ZERO;
        end
    end

endmodule

// ==== source/BlendPkg.sv ====
// BlendPkg with color, fragment, result and config types plus factor and bus state enums
package BlendPkg;
`include "blend_params.svh"

    typedef logic [`BLEND_SUB_PIXEL_WIDTH - 1 : 0] subPixel_t;

    // Red in the top byte, alpha in the bottom byte
    typedef struct packed {
        subPixel_t r;
        subPixel_t g;
        subPixel_t b;
        subPixel_t a;
    } rgba_t;

    // OpenGL style blend factor codes
    typedef enum logic [3 : 0] {
        ZERO                = 4'd0,
        ONE                 = 4'd1,
        DST_COLOR           = 4'd2,
        SRC_COLOR           = 4'd3,
        ONE_MINUS_DST_COLOR = 4'd4,
        ONE_MINUS_SRC_COLOR = 4'd5,
        SRC_ALPHA           = 4'd6,
        ONE_MINUS_SRC_ALPHA = 4'd7,
        DST_ALPHA           = 4'd8,
        ONE_MINUS_DST_ALPHA = 4'd9,
        SRC_ALPHA_SATURATE  = 4'd10
    } blendFactor_e;

    // Same bit order as the CONFIG register, source in the low nibble
    typedef struct packed {
        blendFactor_e dstFactor;
        blendFactor_e srcFactor;
    } blendConfig_t;

    typedef struct packed {
        rgba_t                            sourceColor;
        rgba_t                            destColor;
        logic [`BLEND_TAG_WIDTH - 1 : 0]  tag;
    } fragment_t;

    typedef struct packed {
        rgba_t                            color;
        logic [`BLEND_TAG_WIDTH - 1 : 0]  tag;
    } blendResult_t;

    typedef enum logic {
        IDLE,
        ACK
    } busState_e;

endpackage

// ==== source/ColorBlender.sv ====
// ColorBlender, blend factor selection ahead of ColorMixer with valid and tag pipeline
`timescale 1ns/10ps
`include "blend_params.svh"

module ColorBlender
    import BlendPkg::*;
(
    input  logic            aclk,
    input  logic            arstN,

    input  blendConfig_t    blendConfig,

    input  logic            fragmentValid,
    input  fragment_t       fragment,

    output logic            resultValid,
    output blendResult_t    result
);

    localparam subPixel_t ONE_POINT_ZERO = '1;

    blendFactor_e                       srcFactor;
    blendFactor_e                       dstFactor;
    rgba_t                              srcFactorColor;
    rgba_t                              dstFactorColor;
    rgba_t                              mixedColor;
    logic                               validStage1;
    logic                               validStage2;
    logic [`BLEND_TAG_WIDTH - 1 : 0]    tagStage1;
    logic [`BLEND_TAG_WIDTH - 1 : 0]    tagStage2;

    // Source side cannot use the source color as its own factor
    function automatic blendFactor_e legalSource(input blendFactor_e f);
        case (f)
            SRC_COLOR, ONE_MINUS_SRC_COLOR:
                legalSource = ZERO;
            default:
                legalSource = f;
        endcase
    endfunction

    function automatic blendFactor_e legalDest(input blendFactor_e f);
        case (f)
            DST_COLOR, ONE_MINUS_DST_COLOR, SRC_ALPHA_SATURATE:
                legalDest = ZERO;
            default:
                legalDest = f;
        endcase
    endfunction

    // Per-channel factor; 255 minus a channel is its bitwise inverse
    function automatic rgba_t factorColor(
        input blendFactor_e f,
        input rgba_t        s,
        input rgba_t        d
    );
        subPixel_t  saturate;
        rgba_t      fc;
        saturate = (s.a < ~d.a) ? s.a : ~d.a;
        case (f)
            ONE:                 fc = {4{ONE_POINT_ZERO}};
            DST_COLOR:           fc = d;
            SRC_COLOR:           fc = s;
            ONE_MINUS_DST_COLOR: fc = ~d;
            ONE_MINUS_SRC_COLOR: fc = ~s;
            SRC_ALPHA:           fc = {4{s.a}};
            ONE_MINUS_SRC_ALPHA: fc = {4{~s.a}};
            DST_ALPHA:           fc = {4{d.a}};
            ONE_MINUS_DST_ALPHA: fc = {4{~d.a}};
            SRC_ALPHA_SATURATE:  fc = {saturate, saturate, saturate, ONE_POINT_ZERO};
            // ZERO and codes 11 to 15
            default:             fc = '0;
        endcase
        factorColor = fc;
    endfunction

    assign srcFactor = legalSource(blendConfig.srcFactor);
    assign dstFactor = legalDest(blendConfig.dstFactor);

    assign srcFactorColor = factorColor(srcFactor, fragment.sourceColor, fragment.destColor);
    assign dstFactorColor = factorColor(dstFactor, fragment.sourceColor, fragment.destColor);

    ColorMixer colorMixer (
        .aclk(aclk),
        .arstN(arstN),
        .colorA(srcFactorColor),
        .colorB(fragment.sourceColor),
        .colorC(dstFactorColor),
        .colorD(fragment.destColor),
        .mixedColor(mixedColor)
    );

    // Valid follows the mixer depth
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            validStage1 <= 1'b0;
            validStage2 <= 1'b0;
        end
        else
        begin
            validStage1 <= fragmentValid;
            validStage2 <= validStage1;
        end
    end

    always_ff @(posedge aclk)
    begin
        tagStage1 <= fragment.tag;
        tagStage2 <= tagStage1;
    end

    assign resultValid = validStage2;
    assign result.color = mixedColor;
    assign result.tag = tagStage2;

endmodule

// ==== source/ColorMixer.sv ====
// ColorMixer, two-stage per-channel multiply-add with rounding and saturation
`timescale 1ns/10ps
`include "blend_params.svh"

module ColorMixer
    import BlendPkg::*;
(
    input  logic    aclk,
    input  logic    arstN,

    input  rgba_t   colorA,
    input  rgba_t   colorB,
    input  rgba_t   colorC,
    input  rgba_t   colorD,

    output rgba_t   mixedColor
);

    localparam int SUB_WIDTH = `BLEND_SUB_PIXEL_WIDTH;
    localparam int PRODUCT_WIDTH = 2 * SUB_WIDTH;
    localparam int SUM_WIDTH = PRODUCT_WIDTH + 1;
    localparam subPixel_t ONE_POINT_ZERO = '1;

    // Index 3 is red, index 0 is alpha
    logic [3 : 0][SUB_WIDTH - 1 : 0]        chanA;
    logic [3 : 0][SUB_WIDTH - 1 : 0]        chanB;
    logic [3 : 0][SUB_WIDTH - 1 : 0]        chanC;
    logic [3 : 0][SUB_WIDTH - 1 : 0]        chanD;
    logic [3 : 0][PRODUCT_WIDTH - 1 : 0]    prodAB;
    logic [3 : 0][PRODUCT_WIDTH - 1 : 0]    prodCD;
    logic [3 : 0][SUB_WIDTH - 1 : 0]        mixed;

    // Add 255, drop 8 bits, clamp anything above full scale
    function automatic subPixel_t roundSaturate(
        input logic [PRODUCT_WIDTH - 1 : 0] p0,
        input logic [PRODUCT_WIDTH - 1 : 0] p1
    );
        logic [SUM_WIDTH - 1 : 0]               sum;
        logic [SUM_WIDTH - SUB_WIDTH - 1 : 0]   shifted;
        sum = {1'b0, p0} + {1'b0, p1} + SUM_WIDTH'(ONE_POINT_ZERO);
        shifted = sum[SUM_WIDTH - 1 : SUB_WIDTH];
        roundSaturate = shifted[SUM_WIDTH - SUB_WIDTH - 1] ? ONE_POINT_ZERO
                                                           : shifted[SUB_WIDTH - 1 : 0];
    endfunction

    assign chanA = colorA;
    assign chanB = colorB;
    assign chanC = colorC;
    assign chanD = colorD;

    // Stage one, products
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            prodAB <= '0;
            prodCD <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                prodAB[i] <= chanA[i] * chanB[i];
                prodCD[i] <= chanC[i] * chanD[i];
            end
        end
    end

    // Stage two, rounded and saturated sum
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            mixed <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                mixed[i] <= roundSaturate(prodAB[i], prodCD[i]);
            end
        end
    end

    assign mixedColor = mixed;

endmodule

// ==== source/PixelBlendUnit.sv ====
// PixelBlendUnit, top level joining the bus control block and the blend datapath
`timescale 1ns/10ps
`include "blend_params.svh"

module PixelBlendUnit
    import BlendPkg::*;
(
    input  logic                                    aclk,
    input  logic                                    arstN,

    // Wishbone classic slave
    input  logic                                    wbCyc,
    input  logic                                    wbStb,
    input  logic                                    wbWe,
    input  logic [`BLEND_WB_ADDR_WIDTH - 1 : 0]     wbAdr,
    input  logic [`BLEND_WB_DATA_WIDTH - 1 : 0]     wbDatW,
    input  logic [`BLEND_WB_DATA_WIDTH / 8 - 1 : 0] wbSel,
    output logic [`BLEND_WB_DATA_WIDTH - 1 : 0]     wbDatR,
    output logic                                    wbAck,

    // Fragment stream, no back-pressure
    input  logic                                    fragmentValid,
    input  fragment_t                               fragment,
    output logic                                    resultValid,
    output blendResult_t                            result
);

    blendConfig_t blendConfig;

    BlendControl blendControl (
        .aclk(aclk),
        .arstN(arstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbSel(wbSel),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .resultValid(resultValid),
        .blendConfig(blendConfig)
    );

    ColorBlender colorBlender (
        .aclk(aclk),
        .arstN(arstN),
        .blendConfig(blendConfig),
        .fragmentValid(fragmentValid),
        .fragment(fragment),
        .resultValid(resultValid),
        .result(result)
    );

endmodule

// ==== source/blend_params.svh ====
// Channel, tag and bus widths plus register offsets of the pixel blend unit
`ifndef BLEND_PARAMS_SVH
`define BLEND_PARAMS_SVH

// Bits per color channel, RGBA8
`define BLEND_SUB_PIXEL_WIDTH 8
// Framebuffer address tag carried with each fragment
`define BLEND_TAG_WIDTH 16

// Wishbone slave bus
`define BLEND_WB_ADDR_WIDTH 4
`define BLEND_WB_DATA_WIDTH 32

// Register byte offsets
`define BLEND_REG_CONFIG 0
`define BLEND_REG_COUNT 4

`endif

// ==== verif/PixelBlendTb.sv ====
// Testbench with clock, reset, Wishbone tasks, blend reference model and assertions
`timescale 1ns/10ps
`include "blend_params.svh"

module PixelBlendTb
    import BlendPkg::*;
();

    localparam int BUS_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 60;

    logic                                       aclk;
    logic                                       arstN;
    logic                                       wbCyc;
    logic                                       wbStb;
    logic                                       wbWe;
    logic [`BLEND_WB_ADDR_WIDTH - 1 : 0]        wbAdr;
    logic [`BLEND_WB_DATA_WIDTH - 1 : 0]        wbDatW;
    logic [`BLEND_WB_DATA_WIDTH / 8 - 1 : 0]    wbSel;
    logic [`BLEND_WB_DATA_WIDTH - 1 : 0]        wbDatR;
    logic                                       wbAck;
    logic                                       fragmentValid;
    fragment_t                                  fragment;
    logic                                       resultValid;
    blendResult_t                               result;

    blendResult_t   expectQ[$];
    // Register state that applies to the next sampled fragment
    logic [3 : 0]   modelSrc;
    logic [3 : 0]   modelDst;
    logic           modelEnable;
    int             errorCount;
    int             testsRun;
    int             testsFailed;
    int             errorsAtTestStart;

    PixelBlendUnit PixelBlendUnit_i (
        .aclk(aclk),
        .arstN(arstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbSel(wbSel),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .fragmentValid(fragmentValid),
        .fragment(fragment),
        .resultValid(resultValid),
        .result(result)
    );

    initial
    begin
        aclk = 1'b0;
        forever
            #5 aclk = ~aclk;
    end

    task automatic logError(input string msg);
        errorCount++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    // Factor for one channel with ch 0 as alpha and ch 3 as red
    function automatic int factorFor(input int code, input bit sourceSide, input int ch,
                                     input rgba_t s, input rgba_t d);
        int sa;
        int da;
        sa = s.a;
        da = d.a;
        if (sourceSide && (code == 3 || code == 5))
            return 0;
        if (!sourceSide && (code == 2 || code == 4 || code == 10))
            return 0;
        case (code)
            1:       return 255;
            2:       return d[8 * ch +: 8];
            3:       return s[8 * ch +: 8];
            4:       return 255 - d[8 * ch +: 8];
            5:       return 255 - s[8 * ch +: 8];
            6:       return sa;
            7:       return 255 - sa;
            8:       return da;
            9:       return 255 - da;
            10:      return (ch == 0) ? 255 : ((sa < 255 - da) ? sa : 255 - da);
            default: return 0;
        endcase
    endfunction

    function automatic blendResult_t expectedBlend(input fragment_t f, input logic [3 : 0] srcCode,
                                                   input logic [3 : 0] dstCode, input logic en);
        blendResult_t   r;
        int             srcSel;
        int             dstSel;
        int             sum;
        srcSel = en ? int'(srcCode) : 1;
        dstSel = en ? int'(dstCode) : 0;
        r.tag = f.tag;
        for (int ch = 0; ch < 4; ch++)
        begin
            sum = factorFor(srcSel, 1'b1, ch, f.sourceColor, f.destColor)
                      * f.sourceColor[8 * ch +: 8]
                + factorFor(dstSel, 1'b0, ch, f.sourceColor, f.destColor)
                      * f.destColor[8 * ch +: 8]
                + 255;
            sum = sum >> 8;
            r.color[8 * ch +: 8] = (sum > 255) ? 8'd255 : 8'(sum);
        end
        return r;
    endfunction

    function automatic logic [31 : 0] configWord(input logic [3 : 0] src, input logic [3 : 0] dst,
                                                 input logic en);
        return {23'd0, en, dst, src};
    endfunction

    function automatic fragment_t randomFragment();
        fragment_t f;
        f.sourceColor = rgba_t'($urandom);
        f.destColor = rgba_t'($urandom);
        f.tag = `BLEND_TAG_WIDTH'($urandom);
        return f;
    endfunction

    // Scoreboard compares before pushing and updates the model on a CONFIG ack
    always @(posedge aclk)
    begin
        if (!arstN)
        begin
            expectQ.delete();
            modelSrc = 4'd1;
            modelDst = 4'd0;
            modelEnable = 1'b0;
        end
        else
        begin
            if (resultValid)
            begin
                assert (expectQ.size() != 0)
                else
                    logError("result came out with no fragment pending");
                if (expectQ.size() != 0)
                begin
                    assert (result == expectQ[0])
                    else
                        logError($sformatf("result %h, expected %h", result, expectQ[0]));
                    void'(expectQ.pop_front());
                end
            end
            if (fragmentValid)
                expectQ.push_back(expectedBlend(fragment, modelSrc, modelDst, modelEnable));
            if (wbAck && wbWe && wbAdr == `BLEND_REG_CONFIG)
            begin
                modelSrc = wbDatW[3 : 0];
                modelDst = wbDatW[7 : 4];
                modelEnable = wbDatW[8];
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!arstN) fragmentValid |-> ##2 resultValid)
    else
        logError("resultValid missing two cycles after a fragment");

    assert property (@(posedge aclk) disable iff (!arstN) resultValid |-> $past(fragmentValid, 2))
    else
        logError("resultValid high without a fragment two cycles earlier");

    assert property (@(posedge aclk) disable iff (!arstN) wbAck |=> !wbAck)
    else
        logError("wbAck high for two cycles in a row");

    assert property (@(posedge aclk) disable iff (!arstN) wbAck |-> $past(wbCyc && wbStb))
    else
        logError("wbAck without a preceding strobe");

    task automatic busCycle(input logic write, input logic [`BLEND_WB_ADDR_WIDTH - 1 : 0] addr,
                            input logic [31 : 0] wdata, output logic [31 : 0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(posedge aclk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= write;
        wbAdr <= addr;
        wbDatW <= wdata;
        wbSel <= '1;
        do
        begin
            @(posedge aclk);
            waited++;
        end
        while (!wbAck && waited < BUS_TIMEOUT);
        if (wbAck)
            rdata = wbDatR;
        else
        begin
            errorCount++;
            $display("Bus timeout: no wbAck within %0d cycles for address %0h", BUS_TIMEOUT, addr);
        end
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    task automatic wbWrite(input logic [`BLEND_WB_ADDR_WIDTH - 1 : 0] addr,
                           input logic [31 : 0] data);
        logic [31 : 0] ignored;
        busCycle(1'b1, addr, data, ignored);
    endtask

    task automatic wbRead(input logic [`BLEND_WB_ADDR_WIDTH - 1 : 0] addr,
                          output logic [31 : 0] data);
        busCycle(1'b0, addr, '0, data);
    endtask

    task automatic checkRead(input logic [`BLEND_WB_ADDR_WIDTH - 1 : 0] addr,
                             input logic [31 : 0] expected, input string what);
        logic [31 : 0] data;
        wbRead(addr, data);
        assert (data == expected)
        else
            logError($sformatf("%s read %h, expected %h", what, data, expected));
    endtask

    // Back to back fragments at one per cycle
    task automatic sendFragments(input int count);
        for (int i = 0; i < count; i++)
        begin
            @(posedge aclk);
            fragmentValid <= 1'b1;
            fragment <= randomFragment();
        end
        @(posedge aclk);
        fragmentValid <= 1'b0;
    endtask

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (expectQ.size() != 0 && waited < DRAIN_TIMEOUT)
        begin
            @(posedge aclk);
            waited++;
        end
        if (expectQ.size() != 0)
        begin
            errorCount++;
            $display("Drain timeout: %0d expected results never came out", expectQ.size());
            expectQ.delete();
        end
        @(posedge aclk);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount != errorsAtTestStart)
        begin
            testsFailed++;
            $display("Test %0d %s: failed", testsRun, name);
        end
        else
            $display("Test %0d %s: passed", testsRun, name);
        errorsAtTestStart = errorCount;
    endtask

    initial
    begin
        void'($urandom(32'hd42801b2));
        arstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        wbSel = '0;
        fragmentValid = 1'b0;
        fragment = '0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        errorsAtTestStart = 0;
        repeat (16) @(posedge aclk);
        arstN <= 1'b1;
        @(posedge aclk);

        checkRead(`BLEND_REG_CONFIG, configWord(ONE, ZERO, 1'b0), "CONFIG after reset");
        checkRead(`BLEND_REG_COUNT, 32'd0, "COUNT after reset");
        repeat (8)
        begin
            @(posedge aclk);
            assert (!resultValid)
            else
                logError("resultValid high while no fragments are driven");
        end
        finishTest("reset state");

        sendFragments(32);
        waitForDrain();
        finishTest("pass-through while disabled");

        wbWrite(`BLEND_REG_CONFIG, configWord(SRC_ALPHA, ONE_MINUS_SRC_ALPHA, 1'b1));
        checkRead(`BLEND_REG_CONFIG, configWord(SRC_ALPHA, ONE_MINUS_SRC_ALPHA, 1'b1), "CONFIG");
        sendFragments(32);
        waitForDrain();
        // Additive blend saturates on most random colors
        wbWrite(`BLEND_REG_CONFIG, configWord(ONE, ONE, 1'b1));
        sendFragments(32);
        waitForDrain();
        finishTest("alpha and additive blending");

        for (int src = 0; src < 16; src++)
        begin
            for (int dst = 0; dst < 16; dst++)
            begin
                wbWrite(`BLEND_REG_CONFIG, configWord(4'(src), 4'(dst), 1'b1));
                sendFragments(2);
            end
        end
        waitForDrain();
        finishTest("all factor codes");

        wbWrite(`BLEND_REG_CONFIG, configWord(SRC_ALPHA, ONE_MINUS_SRC_ALPHA, 1'b1));
        fork
            sendFragments(24);
            begin
                repeat (10) @(posedge aclk);
                wbWrite(`BLEND_REG_CONFIG, configWord(ONE_MINUS_DST_COLOR, SRC_ALPHA, 1'b1));
            end
        join
        waitForDrain();
        finishTest("config change mid-stream");

        wbWrite(`BLEND_REG_COUNT, 32'd0);
        checkRead(`BLEND_REG_COUNT, 32'd0, "COUNT after clear");
        sendFragments(13);
        waitForDrain();
        checkRead(`BLEND_REG_COUNT, 32'd13, "COUNT after 13 pixels");
        sendFragments(5);
        waitForDrain();
        checkRead(`BLEND_REG_COUNT, 32'd18, "COUNT after 18 pixels");
        wbWrite(`BLEND_REG_COUNT, 32'hffff_ffff);
        checkRead(`BLEND_REG_COUNT, 32'd0, "COUNT after second clear");
        finishTest("pixel counter");

        $display("%0d of %0d tests passed, %0d errors", testsRun - testsFailed, testsRun,
                 errorCount);
        if (errorCount == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
